// ==== Bender.yml ====
package:
  name: eth_dump

sources:
  - logic/eth_dump_pkg.sv
  - logic/mii_word_assembler.sv
  - logic/frame_word_buffer.sv
  - logic/hex_dump_streamer.sv
  - logic/eth_dump_top.sv
  - target: simulation
    files:
      - verification/eth_dump_tb.sv

// ==== eth_dump.f ====
logic/eth_dump_pkg.sv
logic/mii_word_assembler.sv
logic/frame_word_buffer.sv
logic/hex_dump_streamer.sv
logic/eth_dump_top.sv
verification/eth_dump_tb.sv

// ==== logic/eth_dump_pkg.sv ====
// shared widths and beat types for the ethernet dump path
package eth_dump_pkg;

    // one MII receive nibble
    localparam int nibble_w = 4;

    // buffer word, eight nibbles
    localparam int word_w = 32;
    localparam int nibbles_per_word = 8;

    // one MII receive beat
    // data is taken only while dv is high
    typedef struct packed {
        logic dv;
        logic [nibble_w-1:0] data;
    } mii_beat_t;

    // one ascii character toward the sink
    // valid marks a cycle that spends a credit
    typedef struct packed {
        logic valid;
        logic [7:0] data;
    } char_beat_t;

    // buffer word
    // byte 0 of the frame sits in bits 7:0, nibbles already swapped
    typedef logic [word_w-1:0] word_t;

endpackage

// ==== logic/eth_dump_top.sv ====
`timescale 1ns/100ps

// ethernet frame dump
// MII nibbles in, hex character stream out
module eth_dump_top #(
    parameter int buf_depth = 512,
    parameter int credit_max = 4
) (
    input  logic                     mainclk,
    input  logic                     rst,
    input  eth_dump_pkg::mii_beat_t  mii_rx,
    output eth_dump_pkg::char_beat_t char_out,
    input  logic                     credit_return,
    output logic                     busy
);

    localparam int addr_w = $clog2(buf_depth);
    localparam int cnt_w = $clog2(buf_depth + 1);

    // assembler to buffer
    logic wr_en;
    logic [addr_w-1:0] wr_addr;
    eth_dump_pkg::word_t wr_data;

    // assembler to streamer
    logic frame_done;
    logic [cnt_w-1:0] frame_words;

    // streamer and buffer read port
    logic [addr_w-1:0] rd_addr;
    eth_dump_pkg::word_t rd_data;

    // receive side, holds off while a dump runs
    mii_word_assembler #(
        .buf_depth(buf_depth)
    ) assembler_i (
        .mainclk(mainclk),
        .rst(rst),
        .mii_rx(mii_rx),
        .busy(busy),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .frame_done(frame_done),
        .frame_words(frame_words)
    );

    frame_word_buffer #(
        .buf_depth(buf_depth)
    ) buffer_i (
        .mainclk(mainclk),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    // dump side
    hex_dump_streamer #(
        .buf_depth(buf_depth),
        .credit_max(credit_max)
    ) streamer_i (
        .mainclk(mainclk),
        .rst(rst),
        .frame_done(frame_done),
        .frame_words(frame_words),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .char_out(char_out),
        .credit_return(credit_return),
        .busy(busy)
    );

endmodule

// ==== logic/frame_word_buffer.sv ====
`timescale 1ns/100ps

// word store for one frame
// one write port, one read port with registered output
module frame_word_buffer #(
    parameter int buf_depth = 512
) (
    input  logic                         mainclk,
    input  logic                         wr_en,
    input  logic [$clog2(buf_depth)-1:0] wr_addr,
    input  eth_dump_pkg::word_t          wr_data,
    input  logic [$clog2(buf_depth)-1:0] rd_addr,
    output eth_dump_pkg::word_t          rd_data
);

    localparam int addr_w = $clog2(buf_depth);

    // storage array, maps to block ram
    eth_dump_pkg::word_t mem [buf_depth];

    // read and write addresses as used inside
    logic [addr_w-1:0] wa;
    logic [addr_w-1:0] ra;

    always_comb wa = wr_addr;
    always_comb ra = rd_addr;

    // write side
    // assembler drives a single word per strobe
    always_ff @(posedge mainclk) begin
        if (wr_en) begin
            mem[wa] <= wr_data;
        end
    end

    // read side
    // data for ra shows up the next cycle
    // same-address read during write returns the old word
    always_ff @(posedge mainclk) begin
        rd_data <= mem[ra];
    end

endmodule

// ==== logic/hex_dump_streamer.sv ====
`timescale 1ns/100ps

// reads back a stored frame and sends it as lower-case hex
// paced by sink credits
module hex_dump_streamer #(
    parameter int buf_depth = 512,
    parameter int credit_max = 4
) (
    input  logic                           mainclk,
    input  logic                           rst,
    input  logic                           frame_done,
    input  logic [$clog2(buf_depth+1)-1:0] frame_words,
    output logic [$clog2(buf_depth)-1:0]   rd_addr,
    input  eth_dump_pkg::word_t            rd_data,
    output eth_dump_pkg::char_beat_t       char_out,
    input  logic                           credit_return,
    output logic                           busy
);

    localparam int cnt_w = $clog2(buf_depth + 1);
    localparam int credit_w = $clog2(credit_max + 1);
    localparam int nib_cnt_w = $clog2(eth_dump_pkg::nibbles_per_word);
    localparam int nw = eth_dump_pkg::nibble_w;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_emit
    } state_t;

    state_t state;
    logic [credit_w-1:0] credits;
    logic [cnt_w-1:0] words_left;
    logic [nib_cnt_w-1:0] nib_idx;
    eth_dump_pkg::word_t shift_sr;
    logic send;

    // '0'..'9' then 'a'..'f'
    function automatic logic [7:0] hex_char(input logic [nw-1:0] nib);
        logic [7:0] base;
        base = (nib < 4'd10) ? 8'h30 : 8'h57;
        return base + 8'(nib);
    endfunction

    // one character per cycle while credit remains
    always_comb send = (state == st_emit) && (credits != '0);
    always_comb char_out.valid = send;
    always_comb char_out.data = hex_char(shift_sr[nw-1:0]);
    always_comb busy = (state != st_idle);

    always_ff @(posedge mainclk) begin
        if (rst) begin
            state <= st_idle;
            rd_addr <= '0;
            words_left <= '0;
            nib_idx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // rd_addr already at 0
                    // word 0 arrives during fetch
                    if (frame_done && (frame_words != '0)) begin
                        words_left <= frame_words;
                        state <= st_fetch;
                    end
                end
                st_fetch: begin
                    // prefetch next word while this one is emitted
                    rd_addr <= rd_addr + 1'b1;
                    nib_idx <= '0;
                    state <= st_emit;
                end
                st_emit: begin
                    if (send) begin
                        nib_idx <= nib_idx + 1'b1;
                        if (&nib_idx) begin
                            words_left <= words_left - 1'b1;
                            if (words_left == cnt_w'(1)) begin
                                // park address for the next frame
                                rd_addr <= '0;
                                state <= st_idle;
                            end else begin
                                state <= st_fetch;
                            end
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // character shift register
    // low nibble goes out first
    always_ff @(posedge mainclk) begin
        if (state == st_fetch) begin
            shift_sr <= rd_data;
        end else if (send) begin
            shift_sr <= shift_sr >> nw;
        end
    end

    // credit pool
    // send and return in one cycle cancel
    always_ff @(posedge mainclk) begin
        if (rst) begin
            credits <= credit_w'(credit_max);
        end else if (send && !credit_return) begin
            credits <= credits - 1'b1;
        end else if (!send && credit_return) begin
            credits <= credits + 1'b1;
        end
    end

    // sink returned more than it was granted
    assert property (@(posedge mainclk) disable iff (rst)
        credit_return && (credits == credit_w'(credit_max)) |-> send);
    assert property (@(posedge mainclk) disable iff (rst)
        credits <= credit_w'(credit_max));

endmodule

// ==== logic/mii_word_assembler.sv ====
`timescale 1ns/100ps

// packs MII nibbles into words, swaps nibbles per byte, writes the buffer
module mii_word_assembler #(
    parameter int buf_depth = 512
) (
    input  logic                          mainclk,
    input  logic                          rst,
    input  eth_dump_pkg::mii_beat_t       mii_rx,
    input  logic                          busy,
    output logic                          wr_en,
    output logic [$clog2(buf_depth)-1:0]  wr_addr,
    output eth_dump_pkg::word_t           wr_data,
    output logic                          frame_done,
    output logic [$clog2(buf_depth+1)-1:0] frame_words
);

    localparam int addr_w = $clog2(buf_depth);
    localparam int cnt_w = $clog2(buf_depth + 1);
    localparam int nib_cnt_w = $clog2(eth_dump_pkg::nibbles_per_word);
    localparam int nw = eth_dump_pkg::nibble_w;

    // dv seen last cycle, and whether this frame is being kept
    logic prev_dv;
    logic accept;
    logic frame_start;
    logic take;
    logic [nib_cnt_w-1:0] nib_cnt;
    logic [cnt_w-1:0] word_cnt;
    eth_dump_pkg::word_t shift_sr;
    eth_dump_pkg::word_t shift_next;
    eth_dump_pkg::word_t swapped;

    // first nibble of a frame decides, no start while busy or right at frame_done
    always_comb frame_start = mii_rx.dv && !prev_dv;
    always_comb take = mii_rx.dv && (frame_start ? (!busy && !frame_done) : accept);

    // new nibble enters from the top, first one ends up in bits 3:0
    always_comb shift_next = {mii_rx.data, shift_sr[eth_dump_pkg::word_w-1:nw]};

    // swap the two nibbles of each byte
    always_comb begin
        for (int b = 0; b < eth_dump_pkg::nibbles_per_word / 2; b++) begin
            swapped[b*2*nw +: nw] = shift_next[b*2*nw + nw +: nw];
            swapped[b*2*nw + nw +: nw] = shift_next[b*2*nw +: nw];
        end
    end

    always_ff @(posedge mainclk) begin
        if (take) begin
            shift_sr <= shift_next;
        end
        // word complete, latch data and slot for next-cycle write
        if (take && (&nib_cnt)) begin
            wr_data <= swapped;
            wr_addr <= word_cnt[addr_w-1:0];
        end
        // word total sampled as the frame closes
        if (!mii_rx.dv && prev_dv && accept) begin
            frame_words <= word_cnt;
        end
    end

    always_ff @(posedge mainclk) begin
        if (rst) begin
            prev_dv <= 1'b0;
            accept <= 1'b0;
            nib_cnt <= '0;
            word_cnt <= '0;
            wr_en <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            prev_dv <= mii_rx.dv;
            wr_en <= 1'b0;
            frame_done <= 1'b0;
            if (frame_start) begin
                accept <= !busy && !frame_done;
            end
            if (take) begin
                nib_cnt <= nib_cnt + 1'b1;
                // words past the end of the buffer are dropped
                if ((&nib_cnt) && (word_cnt < cnt_w'(buf_depth))) begin
                    wr_en <= 1'b1;
                    word_cnt <= word_cnt + 1'b1;
                end
            end
            if (!mii_rx.dv) begin
                // partial trailing word is thrown away here
                nib_cnt <= '0;
                word_cnt <= '0;
                accept <= 1'b0;
                frame_done <= prev_dv && accept;
            end
        end
    end

    // buffer must not change under a running dump
    assert property (@(posedge mainclk) disable iff (rst) wr_en |-> !busy);

endmodule

// ==== verification/eth_dump_tb.sv ====
`timescale 1ns/100ps

module eth_dump_tb;

    localparam int credit_max = 4;
    localparam int cycle_limit = 20000;

    logic mainclk = 1'b0;
    logic rst = 1'b1;
    eth_dump_pkg::mii_beat_t mii_rx = '0;
    eth_dump_pkg::char_beat_t char_out;
    logic credit_return = 1'b0;
    logic busy;

    // run bookkeeping
    int cycle = 0;
    int errors = 0;
    int err_mark = 0;
    int tests = 0;
    int failed = 0;

    // sink state
    // delay_mode 0 returns next cycle, 1 returns after a random wait
    int outstanding = 0;
    int delay_mode = 0;
    logic hold = 1'b0;
    logic quiet = 1'b0;
    logic stalled = 1'b0;
    logic [7:0] got_q[$];
    logic [7:0] exp_q[$];
    logic [7:0] frame_q[$];
    int due_q[$];

    eth_dump_top dut_i (
        .mainclk(mainclk),
        .rst(rst),
        .mii_rx(mii_rx),
        .char_out(char_out),
        .credit_return(credit_return),
        .busy(busy)
    );

    always #20 mainclk = ~mainclk;

    // hard stop well past the longest expected run
    always @(posedge mainclk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    // characters are stable mid-cycle
    always @(negedge mainclk) begin
        if (!rst && char_out.valid) begin
            got_q.push_back(char_out.data);
            outstanding++;
            due_q.push_back(cycle + ((delay_mode == 0) ? 1 : 1 + int'($urandom % 8)));
        end
    end

    // one credit pulse per consumed character, none while held
    always @(posedge mainclk) begin
        #2;
        if (!hold && due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            outstanding--;
            credit_return = 1'b1;
        end else begin
            credit_return = 1'b0;
        end
    end

    // sink never holds more than the granted credits
    assert property (@(posedge mainclk) disable iff (rst)
        outstanding >= 0 && outstanding <= credit_max)
    else begin
        errors++;
        $display("credit rule broken at %0t, %0d characters outstanding", $time, outstanding);
    end

    assert property (@(posedge mainclk) $fell(rst) |-> !busy && !char_out.valid)
    else begin
        errors++;
        $display("busy or a character was active right after reset at %0t", $time);
    end

    // no mii activity, so nothing may come out
    assert property (@(posedge mainclk) disable iff (rst) quiet |-> !busy && !char_out.valid)
    else begin
        errors++;
        $display("output activity without any received frame at %0t", $time);
    end

    assert property (@(posedge mainclk) disable iff (rst) stalled |-> !char_out.valid)
    else begin
        errors++;
        $display("character sent while all credits were withheld at %0t", $time);
    end

    function automatic logic [7:0] hex_of(input logic [3:0] n);
        string digits;
        digits = "0123456789abcdef";
        return digits[n];
    endfunction

    // wire order, high nibble first, partial word dropped
    task automatic build_expected();
        int whole;
        exp_q.delete();
        whole = frame_q.size() / 4 * 4;
        for (int i = 0; i < whole; i++) begin
            exp_q.push_back(hex_of(frame_q[i][7:4]));
            exp_q.push_back(hex_of(frame_q[i][3:0]));
        end
    endtask

    task automatic random_frame(input int n);
        frame_q.delete();
        repeat (n) frame_q.push_back(8'($urandom));
    endtask

    // low nibble of each byte goes first on the wire
    task automatic send_frame();
        foreach (frame_q[i]) begin
            for (int h = 0; h < 2; h++) begin
                @(posedge mainclk);
                #2;
                mii_rx.dv = 1'b1;
                mii_rx.data = (h == 0) ? frame_q[i][3:0] : frame_q[i][7:4];
            end
        end
        @(posedge mainclk);
        #2;
        mii_rx = '0;
    endtask

    task automatic wait_dump_done();
        do @(negedge mainclk); while (!busy);
        do @(negedge mainclk); while (busy || due_q.size() != 0);
    endtask

    task automatic start_test();
        repeat (10) @(negedge mainclk);
        err_mark = errors;
        got_q.delete();
    endtask

    task automatic finish_test(input string name);
        assert (got_q.size() == exp_q.size())
        else begin
            errors++;
            $display("ERROR t=%0t char_out count expected %0d got %0d", $time,
                     exp_q.size(), got_q.size());
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            assert (got_q[i] == exp_q[i])
            else begin
                errors++;
                $display("ERROR t=%0t char_out.data[%0d] expected %c got %c", $time, i,
                         exp_q[i], got_q[i]);
            end
        end
        tests++;
        if (errors != err_mark) failed++;
        $display("test %0d %s: %s, %0d characters", tests, name,
                 (errors == err_mark) ? "ok" : "failing", got_q.size());
    endtask

    initial begin
        void'($urandom(32'hab19));
        repeat (4) @(posedge mainclk);
        #2;
        rst = 1'b0;

        // quiet line after reset
        start_test();
        exp_q.delete();
        quiet = 1'b1;
        repeat (50) @(negedge mainclk);
        quiet = 1'b0;
        finish_test("idle_after_reset");

        start_test();
        frame_q = '{8'h12, 8'h34, 8'hab, 8'hcd};
        build_expected();
        send_frame();
        wait_dump_done();
        finish_test("four_byte_frame");

        // slow, uneven sink
        start_test();
        delay_mode = 1;
        random_frame(64);
        build_expected();
        send_frame();
        wait_dump_done();
        delay_mode = 0;
        finish_test("random_frame_random_credits");

        // stall mid dump until credits run dry, then 200 cycles more
        start_test();
        random_frame(32);
        build_expected();
        send_frame();
        do @(negedge mainclk); while (got_q.size() < 20);
        hold = 1'b1;
        do @(negedge mainclk); while (outstanding != credit_max);
        @(negedge mainclk);
        stalled = 1'b1;
        repeat (200) @(negedge mainclk);
        stalled = 1'b0;
        hold = 1'b0;
        do @(negedge mainclk); while (busy || due_q.size() != 0);
        finish_test("credit_stall");

        // second frame lands while the first is still dumping
        start_test();
        random_frame(6);
        build_expected();
        send_frame();
        do @(negedge mainclk); while (!busy);
        random_frame(8);
        send_frame();
        do @(negedge mainclk); while (busy || due_q.size() != 0);
        repeat (20) @(negedge mainclk);
        finish_test("partial_word_and_busy_frame");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
